// File: include/panel_consts.svh
/*
 * front panel constants
 * debounce length, boot address, display scan rate and step-rate dividers
 */

`ifndef PANEL_CONSTS_SVH
`define PANEL_CONSTS_SVH

`define DEBOUNCE_CYCLES 8          // cycles a button must hold still
`define BOOT_PC         14'h0100   // pc loaded by the boot button
`define SCAN_BITS       4          // 2^SCAN_BITS cycles per display digit

// ----------------------------------------------------------------------
// step rate, one step per 2^n cycles of the free-running counter
`define RATE_COUNT_BITS 23
`define RATE_BITS_SW6   19
`define RATE_BITS_SW5   7
`define RATE_BITS_SW4   6
`define RATE_BITS_SW3   5
`define RATE_BITS_SW2   3
`define RATE_BITS_SW1   2
`define RATE_BITS_SW0   1

`endif

// File: source/panel_pkg.sv
/*
 * front panel types
 * vector widths, run state encoding and the structs passed between blocks
 */

package panel_pkg;

   typedef logic [13:0] pc_t;        // machine program counter
   typedef logic [3:0]  digit_t;     // one hex nibble on the display
   typedef logic [3:0]  button_t;    // 3 reset, 2 boot, 1 halt, 0 continue
   typedef logic [6:0]  rate_sel_t;  // slide switches 6..0

   typedef enum logic [1:0] {
      st_halted,
      st_run,
      st_reset
   } run_state_e;

   // one-cycle control pulses out of the button logic
   typedef struct packed {
      logic reset;
      logic boot;
      logic halt;
      logic cont;
   } panel_ctl_t;

   typedef struct packed {
      pc_t  pc;
      logic machrun;
      logic halted;
   } machine_status_t;

endpackage

// File: source/step_rate_gen.sv
/*
 * step rate generator
 * free-running counter divided down by the highest set slide switch,
 * gives a one-cycle step strobe for the run controller
 */

`timescale 1ns/1ps

`include "panel_consts.svh"

module step_rate_gen (
   input  logic                 clk100,
   input  logic                 rst,
   input  panel_pkg::rate_sel_t rate_sel,
   output logic                 step
);

   localparam int CW = `RATE_COUNT_BITS;

   logic [CW-1:0] slow;
   logic [4:0]    div_bits;   // log2 of the step period
   logic [CW-1:0] mask;

   // ----------------------------------------------------------------------
   // highest switch wins, no switch means a step every cycle
   always_comb begin
      if (rate_sel[6])
         div_bits = 5'(`RATE_BITS_SW6);
      else if (rate_sel[5])
         div_bits = 5'(`RATE_BITS_SW5);
      else if (rate_sel[4])
         div_bits = 5'(`RATE_BITS_SW4);
      else if (rate_sel[3])
         div_bits = 5'(`RATE_BITS_SW3);
      else if (rate_sel[2])
         div_bits = 5'(`RATE_BITS_SW2);
      else if (rate_sel[1])
         div_bits = 5'(`RATE_BITS_SW1);
      else if (rate_sel[0])
         div_bits = 5'(`RATE_BITS_SW0);
      else
         div_bits = 5'd0;
   end

   assign mask = (CW'(1) << div_bits) - CW'(1);   // low bits that must be all ones

   always_ff @(posedge clk100) begin
      if (rst) begin
         slow <= '0;
         step <= 1'b0;
      end else begin
         slow <= slow + 1'b1;
         step <= &(slow | ~mask);   // empty mask gives a constant step
      end
   end

endmodule

// File: source/button_sequencer.sv
/*
 * button sequencer
 * synchronizes and debounces the four panel buttons and turns each press
 * into a single control pulse, reset first, continue last
 */

`timescale 1ns/1ps

`include "panel_consts.svh"

module button_sequencer (
   input  logic                  clk100,
   input  logic                  rst,
   input  panel_pkg::button_t    button,
   output panel_pkg::panel_ctl_t ctl
);

   localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DEBOUNCE_CYCLES - 1);

   panel_pkg::button_t sync_a;
   panel_pkg::button_t sync_b;
   panel_pkg::button_t level;     // debounced button level
   panel_pkg::button_t level_q;
   panel_pkg::button_t rise;
   logic [CNT_W-1:0]   stable_cnt [4];

   // ----------------------------------------------------------------------
   // two-flop synchronizer, buttons are asynchronous to clk100
   always_ff @(posedge clk100) begin
      if (rst) begin
         sync_a <= '0;
         sync_b <= '0;
      end else begin
         sync_a <= button;
         sync_b <= sync_a;
      end
   end

   // ----------------------------------------------------------------------
   // level only follows the input after it differs for DEBOUNCE_CYCLES
   always_ff @(posedge clk100) begin
      if (rst) begin
         level   <= '0;
         level_q <= '0;
         for (int i = 0; i < 4; i++)
            stable_cnt[i] <= '0;
      end else begin
         level_q <= level;
         for (int i = 0; i < 4; i++) begin
            if (sync_b[i] == level[i]) begin
               stable_cnt[i] <= '0;             // bounce restarts the count
            end else if (stable_cnt[i] == CNT_LAST) begin
               level[i]      <= sync_b[i];
               stable_cnt[i] <= '0;
            end else begin
               stable_cnt[i] <= stable_cnt[i] + 1'b1;
            end
         end
      end
   end

   assign rise = level & ~level_q;   // press edge, one cycle long

   // a lower priority press in the same cycle is dropped
   always_comb begin
      ctl = '0;
      if (rise[3])
         ctl.reset = 1'b1;
      else if (rise[2])
         ctl.boot = 1'b1;
      else if (rise[1])
         ctl.halt = 1'b1;
      else if (rise[0])
         ctl.cont = 1'b1;
   end

   // at most one pulse at a time, and no pulse is held for two cycles
   a_ctl_pulse: assert property (@(posedge clk100) disable iff (rst)
      $onehot0(ctl) && ((ctl & $past(ctl)) == '0));

endmodule

// File: source/run_control.sv
/*
 * run controller
 * run/halt state machine driven by the panel pulses, advances the pc
 * on every step strobe while running
 */

`timescale 1ns/1ps

`include "panel_consts.svh"

module run_control (
   input  logic                       clk100,
   input  logic                       rst,
   input  logic                       step,
   input  panel_pkg::panel_ctl_t      ctl,
   output panel_pkg::machine_status_t status
);

   panel_pkg::run_state_e state;
   panel_pkg::pc_t        pc;

   // ----------------------------------------------------------------------
   // panel pulses take priority over the current state
   always_ff @(posedge clk100) begin
      if (rst) begin
         state <= panel_pkg::st_halted;
         pc    <= '0;
      end else if (ctl.reset) begin
         state <= panel_pkg::st_reset;
         pc    <= '0;
      end else if (ctl.boot) begin
         state <= panel_pkg::st_run;
         pc    <= `BOOT_PC;
      end else if (ctl.halt) begin
         state <= panel_pkg::st_halted;
      end else begin
         case (state)
            panel_pkg::st_reset:
               state <= panel_pkg::st_halted;   // single cycle
            panel_pkg::st_run:
               if (step)
                  pc <= pc + 1'b1;              // wraps at 14 bits
            panel_pkg::st_halted:
               if (ctl.cont)
                  state <= panel_pkg::st_run;
            default:
               state <= panel_pkg::st_halted;
         endcase
      end
   end

   always_comb begin
      status.pc      = pc;
      status.machrun = (state == panel_pkg::st_run);
      status.halted  = (state == panel_pkg::st_halted);
   end

   // a halted machine keeps its pc, also on the cycle it enters halt
   a_halt_pc: assert property (@(posedge clk100) disable iff (rst)
      state == panel_pkg::st_halted |-> $stable(pc));

endmodule

// File: source/sevenseg_scan.sv
/*
 * seven-segment scanner
 * shows the pc as four hex digits, dots flag run and halt
 */

`timescale 1ns/1ps

`include "panel_consts.svh"

module sevenseg_scan (
   input  logic                       clk100,
   input  logic                       rst,
   input  panel_pkg::machine_status_t status,
   output logic [7:0]                 sevenseg,
   output logic [3:0]                 sevenseg_an
);

   localparam int SCAN_W = `SCAN_BITS + 2;

   logic [SCAN_W-1:0] scan_cnt;
   logic [1:0]        sel;        // digit being driven
   panel_pkg::digit_t nibble;
   logic [6:0]        seg;        // active low, bit 0 is segment a
   logic              dp_on;

   always_ff @(posedge clk100) begin
      if (rst)
         scan_cnt <= '0;
      else
         scan_cnt <= scan_cnt + 1'b1;
   end

   assign sel = scan_cnt[SCAN_W-1 -: 2];

   always_comb begin
      case (sel)
         2'd0: nibble = status.pc[3:0];
         2'd1: nibble = status.pc[7:4];
         2'd2: nibble = status.pc[11:8];
         default: nibble = {2'b00, status.pc[13:12]};
      endcase
   end

   // ----------------------------------------------------------------------
   // hex decode, segments gfedcba active low
   always_comb begin
      case (nibble)
         4'h0: seg = 7'h40;
         4'h1: seg = 7'h79;
         4'h2: seg = 7'h24;
         4'h3: seg = 7'h30;
         4'h4: seg = 7'h19;
         4'h5: seg = 7'h12;
         4'h6: seg = 7'h02;
         4'h7: seg = 7'h78;
         4'h8: seg = 7'h00;
         4'h9: seg = 7'h10;
         4'ha: seg = 7'h08;
         4'hb: seg = 7'h03;
         4'hc: seg = 7'h46;
         4'hd: seg = 7'h21;
         4'he: seg = 7'h06;
         default: seg = 7'h0e;
      endcase
   end

   assign dp_on = (sel == 2'd0 && status.machrun) || (sel == 2'd1 && status.halted);

   assign sevenseg    = {~dp_on, seg};
   assign sevenseg_an = ~(4'b0001 << sel);

   // one anode low, and it only ever moves on to the next digit
   a_anode_scan: assert property (@(posedge clk100) disable iff (rst)
      $onehot(~sevenseg_an) &&
      (!$changed(sevenseg_an) ||
       sevenseg_an == {$past(sevenseg_an[2:0]), $past(sevenseg_an[3])}));

endmodule

// File: source/panel_top.sv
/*
 * front panel top
 * buttons and slide switches in, run controller, display and leds out
 */

`timescale 1ns/1ps

module panel_top (
   input  logic               clk100,
   input  logic               rst,
   input  panel_pkg::button_t button,
   input  logic [7:0]         slideswitch,   // bit 7 not used here
   output logic [7:0]         led,
   output logic [7:0]         sevenseg,
   output logic [3:0]         sevenseg_an
);

   logic                       step;
   panel_pkg::panel_ctl_t      ctl;
   panel_pkg::machine_status_t status;

   // ----------------------------------------------------------------------
   step_rate_gen u_rate (
      .clk100   (clk100),
      .rst      (rst),
      .rate_sel (slideswitch[6:0]),
      .step     (step)
   );

   button_sequencer u_buttons (
      .clk100 (clk100),
      .rst    (rst),
      .button (button),
      .ctl    (ctl)
   );

   run_control u_run (
      .clk100 (clk100),
      .rst    (rst),
      .step   (step),
      .ctl    (ctl),
      .status (status)
   );

   sevenseg_scan u_scan (
      .clk100      (clk100),
      .rst         (rst),
      .status      (status),
      .sevenseg    (sevenseg),
      .sevenseg_an (sevenseg_an)
   );

   assign led[0]   = status.machrun;
   assign led[1]   = status.halted;
   assign led[2]   = step;              // flickers at fast rates
   assign led[7:3] = status.pc[13:9];

endmodule

// File: verification/panel_tests.svh
/*
 * front panel directed tests
 * button press helpers, display readout and one task per test
 */

`ifndef PANEL_TESTS_SVH
`define PANEL_TESTS_SVH

task automatic report_mismatch(input string msg, input int expected, input int seen);
   $display("mismatch at %0t: %s expected %0h seen %0h", $time, msg, expected, seen);
   errors++;
endtask

// hold long enough to pass the debounce, then let the release settle
task automatic press_button(input int idx);
   @(posedge clk100);
   button[idx] <= 1'b1;
   repeat (`DEBOUNCE_CYCLES + 4) @(posedge clk100);
   button[idx] <= 1'b0;
   repeat (`DEBOUNCE_CYCLES + 4) @(posedge clk100);
endtask

task automatic glitch_button(input int idx, input int len);
   @(posedge clk100);
   button[idx] <= 1'b1;
   repeat (len) @(posedge clk100);
   button[idx] <= 1'b0;
   repeat (`DEBOUNCE_CYCLES + 4) @(posedge clk100);
endtask

// active low segments back to {valid, nibble}
function automatic logic [4:0] decode_segments(input logic [6:0] seg_n);
   case (~seg_n)
      7'h3f: return 5'h10;
      7'h06: return 5'h11;
      7'h5b: return 5'h12;
      7'h4f: return 5'h13;
      7'h66: return 5'h14;
      7'h6d: return 5'h15;
      7'h7d: return 5'h16;
      7'h07: return 5'h17;
      7'h7f: return 5'h18;
      7'h6f: return 5'h19;
      7'h77: return 5'h1a;
      7'h7c: return 5'h1b;
      7'h39: return 5'h1c;
      7'h5e: return 5'h1d;
      7'h79: return 5'h1e;
      7'h71: return 5'h1f;
      default: return 5'h00;
   endcase
endfunction

// samples on the falling edge until every anode slot was seen
task automatic read_display(output panel_pkg::pc_t pc, output logic run_dot,
                            output logic halt_dot);
   logic [3:0] seen;
   logic [4:0] dec;
   logic [3:0] dig [4];
   int         n;
   seen     = '0;
   n        = 0;
   run_dot  = 1'b0;
   halt_dot = 1'b0;
   for (int j = 0; j < 4; j++)
      dig[j] = '0;
   while (seen != 4'hf && n < 200) begin
      @(negedge clk100);
      n++;
      for (int j = 0; j < 4; j++) begin
         if (sevenseg_an == ~(4'b0001 << j)) begin
            dec = decode_segments(sevenseg[6:0]);
            if (!dec[4]) begin
               $display("error at %0t: digit %0d shows no hex pattern", $time, j);
               errors++;
            end
            dig[j]  = dec[3:0];
            seen[j] = 1'b1;
            if (j == 0) run_dot = ~sevenseg[7];
            if (j == 1) halt_dot = ~sevenseg[7];
         end
      end
   end
   if (seen != 4'hf) begin
      $display("error at %0t: display scan did not reach all four digits", $time);
      errors++;
   end
   pc = {dig[3][1:0], dig[2], dig[1], dig[0]};
endtask

// ----------------------------------------------------------------------
task automatic test_after_reset();
   panel_pkg::pc_t pc;
   logic           run_dot;
   logic           halt_dot;
   @(negedge clk100);
   if (sevenseg_an != 4'b1110) report_mismatch("anode after reset", 4'he, sevenseg_an);
   read_display(pc, run_dot, halt_dot);
   if (pc != 14'h0) report_mismatch("pc after reset", 0, pc);
   if (run_dot || !halt_dot) report_mismatch("dots after reset", 2'b01, {run_dot, halt_dot});
   if (led[0] !== 1'b0) report_mismatch("led[0] after reset", 0, led[0]);
   if (led[1] !== 1'b1) report_mismatch("led[1] after reset", 1, led[1]);
endtask

task automatic test_boot_halt();
   panel_pkg::pc_t pc;
   logic           run_dot;
   logic           halt_dot;
   press_button(btn_boot);
   press_button(btn_halt);
   read_display(pc, run_dot, halt_dot);
   if (pc < `BOOT_PC + 1) report_mismatch("pc after boot, min", `BOOT_PC + 1, pc);
   if (run_dot || !halt_dot) report_mismatch("dots after halt", 2'b01, {run_dot, halt_dot});
   if (led[1] !== 1'b1) report_mismatch("led[1] after halt", 1, led[1]);
endtask

task automatic test_halt_holds();
   panel_pkg::pc_t pc_a;
   panel_pkg::pc_t pc_b;
   logic           run_dot;
   logic           halt_dot;
   read_display(pc_a, run_dot, halt_dot);
   repeat (200) @(posedge clk100);
   read_display(pc_b, run_dot, halt_dot);
   if (pc_b != pc_a) report_mismatch("pc while halted", pc_a, pc_b);
   press_button(btn_cont);
   repeat (100) @(posedge clk100);
   press_button(btn_halt);
   read_display(pc_b, run_dot, halt_dot);
   if (14'(pc_b - pc_a) < 90) report_mismatch("pc advance, min", 90, 14'(pc_b - pc_a));
endtask

// sw2 steps once per 8 cycles, so 800 running cycles give 100 steps
task automatic test_rate_sw2();
   localparam int debounce_skew = 2;
   localparam int tol = debounce_skew / 8 + 2;
   panel_pkg::pc_t pc_a;
   panel_pkg::pc_t pc_b;
   logic           run_dot;
   logic           halt_dot;
   int             adv;
   @(posedge clk100);
   slideswitch <= 8'b0000_0100;
   read_display(pc_a, run_dot, halt_dot);
   press_button(btn_cont);
   repeat (800 - press_cycles) @(posedge clk100);
   press_button(btn_halt);
   read_display(pc_b, run_dot, halt_dot);
   adv = 14'(pc_b - pc_a);
   if (adv < 100 - tol || adv > 100 + tol) report_mismatch("pc advance at sw2", 100, adv);
endtask

task automatic test_glitch_rejection();
   panel_pkg::pc_t pc_a;
   panel_pkg::pc_t pc_b;
   logic           run_dot;
   logic           halt_dot;
   logic [7:0]     led_a;
   int             len;
   @(posedge clk100);
   slideswitch <= 8'h00;                  // step led then stays high
   repeat (4) @(posedge clk100);
   read_display(pc_a, run_dot, halt_dot);
   led_a = led;
   if (led[2] !== 1'b1) report_mismatch("led[2] with no switch", 1, led[2]);
   if (led[7:3] !== pc_a[13:9]) report_mismatch("led[7:3] against pc", pc_a[13:9], led[7:3]);
   for (int b = 3; b >= 0; b--) begin
      len = $urandom % (`DEBOUNCE_CYCLES - 1) + 1;
      glitch_button(b, len);
      read_display(pc_b, run_dot, halt_dot);
      if (pc_b != pc_a) report_mismatch($sformatf("pc after glitch on %0d", b), pc_a, pc_b);
      if (led != led_a) report_mismatch($sformatf("led after glitch on %0d", b), led_a, led);
   end
endtask

task automatic test_reset_button();
   panel_pkg::pc_t pc;
   logic           run_dot;
   logic           halt_dot;
   press_button(btn_reset);
   read_display(pc, run_dot, halt_dot);
   if (pc != 14'h0) report_mismatch("pc after reset button", 0, pc);
   if (!halt_dot) report_mismatch("halt dot after reset button", 1, halt_dot);
   if (led[1] !== 1'b1) report_mismatch("led[1] after reset button", 1, led[1]);
   press_button(btn_cont);
   press_button(btn_halt);
   read_display(pc, run_dot, halt_dot);
   if (pc == 14'h0) report_mismatch("pc after continue, above", 1, pc);
endtask

`endif

// File: verification/tb_panel_top.sv
/*
 * front panel testbench
 * clock, reset, DUT, watchdog and the directed test sequence
 */

`timescale 1ns/1ps

`include "panel_consts.svh"

module tb_panel_top;

   localparam int btn_reset = 3;
   localparam int btn_boot  = 2;
   localparam int btn_halt  = 1;
   localparam int btn_cont  = 0;

   // one press is a hold plus a release settle, both past the debounce time
   localparam int press_cycles    = 2 * (`DEBOUNCE_CYCLES + 4) + 1;
   localparam int watchdog_cycles = 400000;   // sum of test budgets with margin

   logic               clk100;
   logic               rst;
   panel_pkg::button_t button;
   logic [7:0]         slideswitch;
   logic [7:0]         led;
   logic [7:0]         sevenseg;
   logic [3:0]         sevenseg_an;
   int                 errors;

   initial begin
      clk100 = 1'b0;
      forever #50 clk100 = ~clk100;
   end

   panel_top u_panel_top (
      .clk100      (clk100),
      .rst         (rst),
      .button      (button),
      .slideswitch (slideswitch),
      .led         (led),
      .sevenseg    (sevenseg),
      .sevenseg_an (sevenseg_an)
   );

`include "panel_tests.svh"

   // ----------------------------------------------------------------------
   initial begin
      errors = 0;
      void'($urandom(93));
      rst         = 1'b1;
      button      = '0;
      slideswitch = '0;
      repeat (16) @(posedge clk100);
      rst <= 1'b0;
      test_after_reset();
      test_boot_halt();
      test_halt_holds();
      test_rate_sw2();
      test_glitch_rejection();
      test_reset_button();
      $display("tests done, errors: %0d", errors);
      if (errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

   // watchdog
   initial begin
      repeat (watchdog_cycles) @(posedge clk100);
      $display("error: simulation timed out after %0d cycles", watchdog_cycles);
      $display("Regression failed");
      $finish;
   end

endmodule

// File: panel_top.f
+incdir+include
+incdir+verification
source/panel_pkg.sv
source/step_rate_gen.sv
source/button_sequencer.sv
source/run_control.sv
source/sevenseg_scan.sv
source/panel_top.sv
verification/tb_panel_top.sv
